//--- gcm_aes_top.f
+incdir+tests
hdl/gcm_pkg.sv
hdl/gcm_key_expand.sv
hdl/gcm_counter_stage.sv
hdl/aes_round_pair.sv
hdl/gcm_ghash_stage.sv
hdl/gcm_aes_top.sv
tests/gcm_aes_top_tb.sv

//--- Bender.yml
package:
  name: gcm_aes_top

sources:
  - hdl/gcm_pkg.sv
  - hdl/gcm_key_expand.sv
  - hdl/gcm_counter_stage.sv
  - hdl/aes_round_pair.sv
  - hdl/gcm_ghash_stage.sv
  - hdl/gcm_aes_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/gcm_aes_top_tb.sv

//--- tests/gcm_vectors.svh
`ifndef GCM_VECTORS_SVH
`define GCM_VECTORS_SVH

// published gcm test case 3
// 96-bit iv, four full blocks, no aad
localparam logic [127:0] KAT_KEY = 128'hfeffe992_8665731c_6d6a8f94_67308308;
localparam logic [95:0]  KAT_IV  = 96'hcafebabe_facedbad_decaf888;

// entry 0 is the first block of the message
localparam logic [0:3][127:0] KAT_PLAIN = {
    128'hd9313225_f88406e5_a55909c5_aff5269a,
    128'h86a7a953_1534f7da_2e4c303d_8a318a72,
    128'h1c3c0c95_95680953_2fcf0e24_49a6b525,
    128'hb16aedf5_aa0de657_ba637b39_1aafd255
};

localparam logic [0:3][127:0] KAT_CIPHER = {
    128'h42831ec2_21777424_4b7221b7_84d0d49c,
    128'he3aa212f_2c02a4e0_35c17e23_29aca12e,
    128'h21d514b2_5466931c_7d8f6a5a_ac84aa05,
    128'h1ba30b39_6a0aac97_3d58e091_473f5985
};

// tag over the ciphertext with the 512-bit length block
localparam logic [127:0] KAT_TAG = 128'h4d5c2af3_27cd64a6_2cf35abd_2ba6fab4;

`endif

//--- tests/gcm_aes_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_aes_top_tb;
    import gcm_pkg::*;

    `include "gcm_vectors.svh"

    localparam int BLOCKS_PER_MSG = 4;
    localparam int CT_LATENCY     = 8;
    localparam int TAG_LATENCY    = 9;
    localparam int GAP_CYCLES     = 12;
    localparam int RANDOM_BLOCKS  = 16;
    localparam int DRAIN_CYCLES   = TAG_LATENCY + 1;
    // four messages, two gaps, random blocks and the drain
    localparam int TOTAL_BLOCKS   = 4 * BLOCKS_PER_MSG + 2 * GAP_CYCLES + RANDOM_BLOCKS
                                    + DRAIN_CYCLES;
    localparam int WATCHDOG_NS    = (TOTAL_BLOCKS + 50) * 40;

    typedef struct packed {
        logic [31:0] due;
        block_t      value;
    } ct_exp_t;

    typedef struct packed {
        logic [31:0] due;
        logic        check;
        block_t      value;
    } tag_exp_t;

    logic     clk;
    logic     i_rst_n;
    logic     i_new_instance;
    aes_key_t i_cipher_key;
    iv_t      i_iv;
    block_t   i_plain_text;
    block_t   o_cipher_text;
    block_t   o_tag;
    logic     o_tag_ready;

    ct_exp_t     ct_q [$];
    tag_exp_t    tag_q [$];
    logic [31:0] cycle;
    logic [31:0] rng_state;

    gcm_aes_top #(
        .BLOCKS_PER_MSG (BLOCKS_PER_MSG)
    ) gcm_aes_top_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_new_instance (i_new_instance),
        .i_cipher_key   (i_cipher_key),
        .i_iv           (i_iv),
        .i_plain_text   (i_plain_text),
        .o_cipher_text  (o_cipher_text),
        .o_tag          (o_tag),
        .o_tag_ready    (o_tag_ready)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random_block(output block_t b);
        int i;
        for (i = 0; i < 4; i++)
        begin
            rng_state = xorshift32(rng_state);
            b[127-32*i -: 32] = rng_state;
        end
    endtask

    // outputs are stable at the falling edge
    task automatic check_outputs();
        ct_exp_t  ce;
        tag_exp_t te;
        if (ct_q.size() > 0 && ct_q[0].due == cycle)
        begin
            ce = ct_q.pop_front();
            assert (o_cipher_text === ce.value)
            else
                abort_run($sformatf("MISMATCH o_cipher_text: got %h, expected %h",
                                    o_cipher_text, ce.value));
        end
        assert (!$isunknown(o_tag_ready))
        else
            abort_run("o_tag_ready is unknown after reset");
        if (tag_q.size() > 0 && tag_q[0].due == cycle)
        begin
            te = tag_q.pop_front();
            assert (o_tag_ready === 1'b1)
            else
                abort_run($sformatf("MISMATCH o_tag_ready: got %h, expected 1", o_tag_ready));
            if (te.check)
            begin
                assert (o_tag === te.value)
                else
                    abort_run($sformatf("MISMATCH o_tag: got %h, expected %h", o_tag, te.value));
            end
        end
        else
        begin
            // only one cycle high and only at a message end
            assert (o_tag_ready === 1'b0)
            else
                abort_run("o_tag_ready went high outside the cycle of a message's tag");
        end
    endtask

    task automatic step();
        @(negedge clk);
        cycle = cycle + 1;
        check_outputs();
    endtask

    task automatic drive_block(input logic first, input block_t pt, input logic check_ct,
                               input block_t exp_ct);
        step();
        i_new_instance = first;
        i_plain_text   = pt;
        if (check_ct)
        begin
            ct_q.push_back(ct_exp_t'{due: cycle + CT_LATENCY, value: exp_ct});
        end
    endtask

    task automatic play_message(input logic [0:3][127:0] pt, input logic [0:3][127:0] exp_ct,
                                input logic check_tag);
        int i;
        for (i = 0; i < BLOCKS_PER_MSG; i++)
        begin
            drive_block(i == 0, pt[i], 1'b1, exp_ct[i]);
        end
        tag_q.push_back(tag_exp_t'{due: cycle + TAG_LATENCY, check: check_tag, value: KAT_TAG});
    endtask

    task automatic insert_gap(input int n);
        repeat (n)
        begin
            drive_block(1'b0, '0, 1'b0, '0);
        end
    endtask

    task automatic feed_random(input int n);
        block_t b;
        repeat (n)
        begin
            next_random_block(b);
            drive_block(1'b0, b, 1'b0, '0);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        abort_run($sformatf("timeout, run still going after %0d ns", WATCHDOG_NS));
    end

    initial
    begin
        i_rst_n        = 1'b0;
        i_new_instance = 1'b0;
        i_cipher_key   = KAT_KEY;
        i_iv           = KAT_IV;
        i_plain_text   = '0;
        cycle          = '0;
        rng_state      = 32'd90549;
        repeat (16) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        // known-answer message with its tag
        play_message(KAT_PLAIN, KAT_CIPHER, 1'b1);
        insert_gap(GAP_CYCLES);
        // two messages in flight together
        play_message(KAT_PLAIN, KAT_CIPHER, 1'b1);
        play_message(KAT_PLAIN, KAT_CIPHER, 1'b1);
        insert_gap(GAP_CYCLES);
        // ctr symmetry with the tag left unchecked
        play_message(KAT_CIPHER, KAT_PLAIN, 1'b0);
        // no new_instance so no tag may follow
        feed_random(RANDOM_BLOCKS);
        insert_gap(DRAIN_CYCLES);

        if (ct_q.size() == 0 && tag_q.size() == 0)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            abort_run("some expected outputs were never checked");
        end
    end

endmodule

`default_nettype wire

//--- hdl/gcm_aes_top.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_aes_top #(
    parameter int BLOCKS_PER_MSG = 4
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_new_instance,
    input  gcm_pkg::aes_key_t i_cipher_key,
    input  gcm_pkg::iv_t      i_iv,
    input  gcm_pkg::block_t   i_plain_text,
    output gcm_pkg::block_t   o_cipher_text,
    output gcm_pkg::block_t   o_tag,
    output logic              o_tag_ready
);
    import gcm_pkg::*;

    iv_t    key_iv;
    stage_t key_stage;
    // entry 0 feeds the first round pair, the last one feeds ghash
    stage_t round_stage [AES_ROUNDS/2 + 1];

    gcm_key_expand key_expand_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_new_instance (i_new_instance),
        .i_cipher_key   (i_cipher_key),
        .i_iv           (i_iv),
        .i_plain_text   (i_plain_text),
        .o_iv           (key_iv),
        .o_stage        (key_stage)
    );

    gcm_counter_stage counter_stage_i (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_iv    (key_iv),
        .i_stage (key_stage),
        .o_stage (round_stage[0])
    );

    // two rounds per stage, five stages
    for (genvar g = 0; g < AES_ROUNDS/2; g++)
    begin : g_round
        aes_round_pair #(
            .FIRST_ROUND (2*g + 1)
        ) round_pair_i (
            .clk     (clk),
            .i_rst_n (i_rst_n),
            .i_stage (round_stage[g]),
            .o_stage (round_stage[g+1])
        );
    end

    gcm_ghash_stage #(
        .BLOCKS_PER_MSG (BLOCKS_PER_MSG)
    ) ghash_stage_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_stage       (round_stage[AES_ROUNDS/2]),
        .o_cipher_text (o_cipher_text),
        .o_tag         (o_tag),
        .o_tag_ready   (o_tag_ready)
    );

endmodule

`default_nettype wire

//--- hdl/gcm_ghash_stage.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_ghash_stage #(
    parameter int BLOCKS_PER_MSG = 4
) (
    input  logic            clk,
    input  logic            i_rst_n,
    input  gcm_pkg::stage_t i_stage,
    output gcm_pkg::block_t o_cipher_text,
    output gcm_pkg::block_t o_tag,
    output logic            o_tag_ready
);
    import gcm_pkg::*;

    localparam int     POS_W     = (BLOCKS_PER_MSG > 1) ? $clog2(BLOCKS_PER_MSG) : 1;
    // 64 zero bits of aad length, then ciphertext length in bits
    localparam block_t LEN_BLOCK = {64'd0, 64'(128 * BLOCKS_PER_MSG)};

    logic             r_first;
    block_t           r_h;
    block_t           r_ej0;
    logic             r_active;
    logic [POS_W-1:0] r_pos;
    block_t           r_s;

    logic [POS_W-1:0] pos;
    logic             is_last;
    block_t           s_next;
    block_t           tag;

    // gf(2^128) multiply, msb of the block is the x^0 coefficient
    function automatic block_t gf_mult(input block_t x, input block_t y);
        block_t z;
        block_t v;
        int     i;
        z = '0;
        v = y;
        for (i = 127; i >= 0; i--)
        begin
            if (x[i])
            begin
                z = z ^ v;
            end
            v = v[0] ? ((v >> 1) ^ {8'he1, 120'd0}) : (v >> 1);
        end
        return z;
    endfunction

    // o_cipher_text is this block's ciphertext while r_* hold its lanes
    always_comb
    begin
        pos     = r_first ? '0 : r_pos;
        is_last = (r_first || r_active) && (pos == POS_W'(BLOCKS_PER_MSG - 1));
        s_next  = gf_mult((r_first ? '0 : r_s) ^ o_cipher_text, r_h);
        // length block folded into the last block's cycle
        tag     = gf_mult(s_next ^ LEN_BLOCK, r_h) ^ r_ej0;
    end

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_first     <= 1'b0;
            r_active    <= 1'b0;
            r_pos       <= '0;
            o_tag_ready <= 1'b0;
        end
        else
        begin
            r_first     <= i_stage.first;
            r_active    <= (r_first || r_active) && !is_last;
            r_pos       <= pos + 1'b1;
            o_tag_ready <= is_last;
        end
    end

    always_ff @(posedge clk)
    begin
        // gctr
        o_cipher_text <= i_stage.plain ^ i_stage.lanes.cb;
        r_h           <= i_stage.lanes.h;
        r_ej0         <= i_stage.lanes.j0;
        r_s           <= s_next;
        if (is_last)
        begin
            o_tag <= tag;
        end
    end

endmodule

`default_nettype wire

//--- hdl/aes_round_pair.sv
`timescale 1ns/1ps
`default_nettype none

module aes_round_pair #(
    parameter int FIRST_ROUND = 1
) (
    input  logic            clk,
    input  logic            i_rst_n,
    input  gcm_pkg::stage_t i_stage,
    output gcm_pkg::stage_t o_stage
);
    import gcm_pkg::*;

    logic        r_first;
    block_t      r_plain;
    aes_lanes_t  r_lanes;
    round_keys_t r_keys;
    aes_lanes_t  lanes_next;

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic word_t mix_column(input word_t col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // byte n of the state sits at bits 127-8n, column-major
    function automatic block_t aes_round(input block_t s, input block_t rk, input logic last);
        block_t sub;
        block_t shf;
        block_t mix;
        int     i;
        int     c;
        int     r;
        for (i = 0; i < 16; i++)
        begin
            sub[127-8*i -: 8] = sbox(s[127-8*i -: 8]);
        end
        // row r rotates left by r columns
        for (c = 0; c < 4; c++)
        begin
            for (r = 0; r < 4; r++)
            begin
                shf[127-8*(4*c+r) -: 8] = sub[127-8*(4*((c+r)%4)+r) -: 8];
            end
        end
        for (c = 0; c < 4; c++)
        begin
            mix[127-32*c -: 32] = mix_column(shf[127-32*c -: 32]);
        end
        return (last ? shf : mix) ^ rk;
    endfunction

    function automatic block_t round_pair(input block_t s, input round_keys_t keys);
        block_t t;
        // initial whitening only in the first pair
        t = (FIRST_ROUND == 1) ? (s ^ keys[0]) : s;
        t = aes_round(t, keys[FIRST_ROUND], FIRST_ROUND == AES_ROUNDS);
        t = aes_round(t, keys[FIRST_ROUND+1], FIRST_ROUND + 1 == AES_ROUNDS);
        return t;
    endfunction

    always_comb
    begin
        lanes_next.h  = round_pair(i_stage.lanes.h, i_stage.keys);
        lanes_next.j0 = round_pair(i_stage.lanes.j0, i_stage.keys);
        lanes_next.cb = round_pair(i_stage.lanes.cb, i_stage.keys);
    end

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_first <= 1'b0;
        end
        else
        begin
            r_first <= i_stage.first;
        end
    end

    always_ff @(posedge clk)
    begin
        r_plain <= i_stage.plain;
        r_lanes <= lanes_next;
    end

    if (FIRST_ROUND + 1 < AES_ROUNDS)
    begin : g_keep_keys
        always_ff @(posedge clk)
        begin
            r_keys <= i_stage.keys;
        end
    end
    else
    begin : g_drop_keys
        // schedule is dead after the last round
        assign r_keys = '0;
    end

    assign o_stage = '{first: r_first, plain: r_plain, lanes: r_lanes, keys: r_keys};

endmodule

`default_nettype wire

//--- hdl/gcm_counter_stage.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_counter_stage (
    input  logic            clk,
    input  logic            i_rst_n,
    input  gcm_pkg::iv_t    i_iv,
    input  gcm_pkg::stage_t i_stage,
    output gcm_pkg::stage_t o_stage
);
    import gcm_pkg::*;

    logic        r_first;
    block_t      r_plain;
    block_t      r_j0;
    block_t      r_cb;
    round_keys_t r_keys;

    block_t      j0;
    block_t      cb_base;
    block_t      cb_next;

    // 96-bit iv case only
    assign j0 = {i_iv, 32'd1};

    always_comb
    begin
        // restart from j0 on a new message, else continue from last block
        cb_base = i_stage.first ? j0 : r_cb;
        cb_next = {cb_base[127:32], cb_base[31:0] + 32'd1};
    end

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_first <= 1'b0;
        end
        else
        begin
            r_first <= i_stage.first;
        end
    end

    always_ff @(posedge clk)
    begin
        r_plain <= i_stage.plain;
        r_j0    <= j0;
        r_cb    <= cb_next;
        r_keys  <= i_stage.keys;
    end

    // h lane encrypts the zero block
    assign o_stage = '{
        first: r_first,
        plain: r_plain,
        lanes: '{h: '0, j0: r_j0, cb: r_cb},
        keys:  r_keys
    };

endmodule

`default_nettype wire

//--- hdl/gcm_key_expand.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_key_expand (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_new_instance,
    input  gcm_pkg::aes_key_t i_cipher_key,
    input  gcm_pkg::iv_t      i_iv,
    input  gcm_pkg::block_t   i_plain_text,
    output gcm_pkg::iv_t      o_iv,
    output gcm_pkg::stage_t   o_stage
);
    import gcm_pkg::*;

    logic        r_first;
    block_t      r_plain;
    round_keys_t r_keys;

    function automatic word_t sub_word(input word_t w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    // whole aes-128 schedule, 44 words
    function automatic round_keys_t expand_key(input aes_key_t key);
        word_t       w [44];
        word_t       temp;
        round_keys_t rk;
        int          i;
        for (i = 0; i < 4; i++)
        begin
            w[i] = key[127-32*i -: 32];
        end
        for (i = 4; i < 44; i++)
        begin
            temp = w[i-1];
            if (i % 4 == 0)
            begin
                // rotword then subword
                temp = sub_word({temp[23:0], temp[31:24]}) ^ {rcon(i / 4), 24'h000000};
            end
            w[i] = w[i-4] ^ temp;
        end
        for (i = 0; i <= AES_ROUNDS; i++)
        begin
            rk[i] = {w[4*i], w[4*i+1], w[4*i+2], w[4*i+3]};
        end
        return rk;
    endfunction

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_first <= 1'b0;
        end
        else
        begin
            r_first <= i_new_instance;
        end
    end

    always_ff @(posedge clk)
    begin
        o_iv    <= i_iv;
        r_plain <= i_plain_text;
        r_keys  <= expand_key(i_cipher_key);
    end

    // lanes are seeded by the counter stage
    assign o_stage = '{first: r_first, plain: r_plain, lanes: '0, keys: r_keys};

endmodule

`default_nettype wire

//--- hdl/gcm_pkg.sv
`default_nettype none

package gcm_pkg;

    localparam int AES_ROUNDS = 10;

    typedef logic [127:0] block_t;
    typedef logic [127:0] aes_key_t;
    typedef logic [95:0]  iv_t;
    typedef logic [31:0]  word_t;

    // index is the round number, 0 is the cipher key itself
    typedef block_t [AES_ROUNDS:0] round_keys_t;

    typedef struct packed {
        block_t h;
        block_t j0;
        block_t cb;
    } aes_lanes_t;

    typedef struct packed {
        logic        first;
        block_t      plain;
        aes_lanes_t  lanes;
        round_keys_t keys;
    } stage_t;

    // forward s-box, entry 0 leftmost
    localparam logic [0:255][7:0] SBOX_TABLE = {
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16
    };

    function automatic logic [7:0] sbox(input logic [7:0] b);
        return SBOX_TABLE[b];
    endfunction

    // round constant for key expansion rounds 1..10
    function automatic logic [7:0] rcon(input int unsigned round);
        logic [7:0] rc;
        case (round)
            1:       rc = 8'h01;
            2:       rc = 8'h02;
            3:       rc = 8'h04;
            4:       rc = 8'h08;
            5:       rc = 8'h10;
            6:       rc = 8'h20;
            7:       rc = 8'h40;
            8:       rc = 8'h80;
            9:       rc = 8'h1b;
            10:      rc = 8'h36;
            default: rc = 8'h00;
        endcase
        return rc;
    endfunction

endpackage

`default_nettype wire
